/* ifetch_settings.svh */
// Cache geometry and thread count for the instruction fetch front end
// Two-way set-associative L1 instruction cache, 32-byte lines

`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// Associativity and number of sets
`define L1I_WAYS 2
`define L1I_SETS 16

// Line geometry, eight 32-bit words per line
`define CACHE_LINE_BYTES 32
`define CACHE_LINE_WORDS 8
`define CACHE_LINE_OFFSET_WIDTH 5

// Hardware threads sharing the fetch unit
`define NUM_THREADS 4

`endif

/* fetch_ctrl_pkg.sv */
// Refill state encoding and Wishbone bus word types

package fetch_ctrl_pkg;
	// Line refill sequence
	typedef enum logic [1:0] {
		// Waiting for a miss
		REFILL_IDLE,
		// Reading line words over the bus
		REFILL_BUS,
		// Single-cycle tag and data write
		REFILL_WRITE
	} refill_state_t;

	// Wishbone address and data words
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
endpackage

/* l1i_types_pkg.sv */
// Address, tag, set, way, line and thread types for the L1 instruction cache

`include "ifetch_settings.svh"

package l1i_types_pkg;
	// Plain machine word
	typedef logic [31:0] scalar_t;

	// Address fields, tag takes what set index and offset leave over
	typedef logic [31 - $clog2(`L1I_SETS) - `CACHE_LINE_OFFSET_WIDTH:0] l1i_tag_t;
	typedef logic [$clog2(`L1I_SETS) - 1:0] l1i_set_idx_t;
	typedef logic [$clog2(`L1I_WAYS) - 1:0] l1i_way_idx_t;

	// Fetch address split into cache fields
	typedef struct packed {
		l1i_tag_t tag;
		l1i_set_idx_t set_idx;
		logic [`CACHE_LINE_OFFSET_WIDTH - 1:0] offset;
	} l1i_addr_t;

	// Whole line, bus word 0 sits in the top lane
	typedef logic [`CACHE_LINE_BYTES * 8 - 1:0] cache_line_data_t;

	typedef logic [$clog2(`NUM_THREADS) - 1:0] thread_idx_t;
endpackage

/* sram_1r1w.sv */
// Single-read single-write memory array
// Registered read port, write data forwarded on same-address collision

`timescale 1ns/1ps

module sram_1r1w #(
	parameter DATA_WIDTH = 32,
	parameter SIZE = 64
) (
	input logic clk,
	input logic read_en,
	input logic [$clog2(SIZE) - 1:0] read_addr,
	output logic [DATA_WIDTH - 1:0] read_data,
	input logic write_en,
	input logic [$clog2(SIZE) - 1:0] write_addr,
	input logic [DATA_WIDTH - 1:0] write_data
);
	logic [DATA_WIDTH - 1:0] mem[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		// Reading the entry under write returns the new value
		if (read_en)
			read_data <= (write_en && write_addr == read_addr) ? write_data : mem[read_addr];
	end
endmodule

/* ifetch_tag_stage.sv */
// Instruction fetch tag stage
// Registers the fetch request, reads tags and valid bits per way
// Keeps one LRU bit per set and names the refill victim

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_tag_stage
	import l1i_types_pkg::*;
(
	input logic clk,
	input logic reset,

	// Fetch request
	input logic fetch_en,
	input l1i_addr_t fetch_pc,
	input thread_idx_t fetch_thread,

	// LRU update from data stage hits
	input logic ifd_update_lru_en,
	input l1i_way_idx_t ifd_update_lru_way,

	// Tag writes from the refill engine
	input logic [`L1I_WAYS - 1:0] itag_update_en_oh,
	input l1i_set_idx_t itag_update_set,
	input l1i_tag_t itag_update_tag,

	// Victim query from the refill engine
	input logic refill_way_req,
	input l1i_set_idx_t refill_set,

	// To data stage
	output logic ift_instruction_requested,
	output l1i_addr_t ift_pc,
	output thread_idx_t ift_thread_idx,
	output l1i_tag_t ift_tag[`L1I_WAYS],
	output logic ift_valid[`L1I_WAYS],
	output l1i_way_idx_t lru_victim_way
);
	// Set bit names the least recently used way
	logic [`L1I_SETS - 1:0] lru_bits;

	genvar way;
	generate
		for (way = 0; way < `L1I_WAYS; way++)
		begin : way_gen
			logic [`L1I_SETS - 1:0] set_valid;
			logic fill_bypass;

			sram_1r1w #(
				.DATA_WIDTH($bits(l1i_tag_t)),
				.SIZE(`L1I_SETS)
			) tag_ram (
				.clk(clk),
				.read_en(fetch_en),
				.read_addr(fetch_pc.set_idx),
				.read_data(ift_tag[way]),
				.write_en(itag_update_en_oh[way]),
				.write_addr(itag_update_set),
				.write_data(itag_update_tag)
			);

			// Line filled in the read cycle counts as valid, like the tag RAM forwarding
			assign fill_bypass = itag_update_en_oh[way] && itag_update_set == fetch_pc.set_idx;

			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
				begin
					set_valid <= '0;
					ift_valid[way] <= 1'b0;
				end
				else
				begin
					if (itag_update_en_oh[way])
						set_valid[itag_update_set] <= 1'b1;
					if (fetch_en)
						ift_valid[way] <= fill_bypass || set_valid[fetch_pc.set_idx];
				end
			end
		end
	endgenerate

	// Victim answer goes straight back to the refill engine
	assign lru_victim_way = lru_bits[refill_set];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ift_instruction_requested <= 1'b0;
			lru_bits <= '0;
		end
		else
		begin
			ift_instruction_requested <= fetch_en;

			// Hit makes the other way least recent
			if (ifd_update_lru_en)
				lru_bits[ift_pc.set_idx] <= ~ifd_update_lru_way;

			// Refill victim becomes most recent, wins over a hit to the same set
			if (refill_way_req)
				lru_bits[refill_set] <= ~lru_victim_way;
		end
	end

	// Request payload
	always_ff @(posedge clk)
	begin
		ift_pc <= fetch_pc;
		ift_thread_idx <= fetch_thread;
	end
endmodule

/* l2_refill.sv */
// Line refill engine
// Wishbone classic master reading one line word by word
// Writes the assembled line and its tag in a single cycle

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module l2_refill
	import l1i_types_pkg::*;
	import fetch_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,

	// Miss request from data stage
	input logic ifd_cache_miss,
	input scalar_t ifd_cache_miss_addr,

	// Victim query to tag stage
	output logic refill_way_req,
	output l1i_set_idx_t refill_set,
	input l1i_way_idx_t lru_victim_way,

	// Wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [3:0] wb_sel,
	output wb_addr_t wb_adr,
	input wb_data_t wb_dat_i,
	input logic wb_ack,

	// Tag update
	output logic [`L1I_WAYS - 1:0] itag_update_en_oh,
	output l1i_set_idx_t itag_update_set,
	output l1i_tag_t itag_update_tag,

	// Data update
	output logic idata_update_en,
	output l1i_way_idx_t idata_update_way,
	output l1i_set_idx_t idata_update_set,
	output cache_line_data_t idata_update_data
);
	refill_state_t state;
	l1i_addr_t miss_req_addr;
	l1i_addr_t fill_addr;
	l1i_way_idx_t fill_way;
	cache_line_data_t fill_line;
	logic [$clog2(`CACHE_LINE_WORDS) - 1:0] word_idx;
	logic word_done;

	assign miss_req_addr = ifd_cache_miss_addr;

	// Only an idle engine takes a miss, others are dropped
	assign refill_way_req = ifd_cache_miss && state == REFILL_IDLE;
	assign refill_set = miss_req_addr.set_idx;

	// Read-only bursts of full words
	assign wb_we = 1'b0;
	assign wb_sel = 4'hf;
	assign wb_adr = {fill_addr.tag, fill_addr.set_idx, word_idx, 2'b00};
	assign word_done = wb_stb && wb_ack;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= REFILL_IDLE;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			word_idx <= '0;
		end
		else
		begin
			unique case (state)
				REFILL_IDLE:
				begin
					if (refill_way_req)
					begin
						state <= REFILL_BUS;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						word_idx <= '0;
					end
				end

				REFILL_BUS:
				begin
					if (word_done)
					begin
						// stb drops between words, cyc only after the last one
						wb_stb <= 1'b0;
						if (word_idx == $bits(word_idx)'(`CACHE_LINE_WORDS - 1))
						begin
							wb_cyc <= 1'b0;
							state <= REFILL_WRITE;
						end
						else
							word_idx <= word_idx + 1'b1;
					end
					else if (!wb_stb)
						wb_stb <= 1'b1;
				end

				REFILL_WRITE:
					state <= REFILL_IDLE;

				default:
					state <= REFILL_IDLE;
			endcase
		end
	end

	// Line address, victim and data payload
	always_ff @(posedge clk)
	begin
		if (refill_way_req)
		begin
			fill_addr <= miss_req_addr;
			fill_way <= lru_victim_way;
		end

		// Bus word k lands in lane 7 - k
		if (word_done)
			fill_line[32 * (`CACHE_LINE_WORDS - 1 - word_idx) +: 32] <= wb_dat_i;
	end

	always_comb
	begin
		itag_update_en_oh = '0;
		if (state == REFILL_WRITE)
			itag_update_en_oh[fill_way] = 1'b1;
	end

	assign itag_update_set = fill_addr.set_idx;
	assign itag_update_tag = fill_addr.tag;

	assign idata_update_en = state == REFILL_WRITE;
	assign idata_update_way = fill_way;
	assign idata_update_set = fill_addr.set_idx;
	assign idata_update_data = fill_line;
endmodule

/* ifetch_data_stage.sv */
// Instruction fetch data stage
// Hit, miss and near-miss detection, LRU update and perf pulses
// Line data read, lane select, byte swap and output registers

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_data_stage
	import l1i_types_pkg::*;
(
	input logic clk,
	input logic reset,

	// From tag stage
	input logic ift_instruction_requested,
	input l1i_addr_t ift_pc,
	input thread_idx_t ift_thread_idx,
	input l1i_tag_t ift_tag[`L1I_WAYS],
	input logic ift_valid[`L1I_WAYS],

	// Tag update from the refill engine
	input logic [`L1I_WAYS - 1:0] itag_update_en_oh,
	input l1i_set_idx_t itag_update_set,
	input l1i_tag_t itag_update_tag,

	// Data update from the refill engine
	input logic idata_update_en,
	input l1i_way_idx_t idata_update_way,
	input l1i_set_idx_t idata_update_set,
	input cache_line_data_t idata_update_data,

	// From back end
	input logic rollback_en,
	input thread_idx_t rollback_thread,

	// To tag stage
	output logic ifd_update_lru_en,
	output l1i_way_idx_t ifd_update_lru_way,

	// To refill engine
	output logic ifd_cache_miss,
	output scalar_t ifd_cache_miss_addr,

	// Fetch result
	output scalar_t instruction,
	output logic instruction_valid,
	output scalar_t instruction_pc,
	output thread_idx_t instruction_thread,

	output logic perf_icache_hit,
	output logic perf_icache_miss
);
	logic [`L1I_WAYS - 1:0] way_hit_oh;
	l1i_way_idx_t way_hit_idx;
	logic cache_hit;
	logic near_miss;
	logic rollback_hit;
	cache_line_data_t fetched_line;
	scalar_t fetched_word;
	logic [$clog2(`CACHE_LINE_WORDS) - 1:0] cache_lane;

	// Way being replaced this cycle cannot hit on its old tag
	always_comb
	begin
		for (int w = 0; w < `L1I_WAYS; w++)
			way_hit_oh[w] = ift_valid[w] && ift_tag[w] == ift_pc.tag
				&& !(itag_update_en_oh[w] && itag_update_set == ift_pc.set_idx);
	end

	// One-hot to index
	always_comb
	begin
		way_hit_idx = '0;
		for (int w = 0; w < `L1I_WAYS; w++)
		begin
			if (way_hit_oh[w])
				way_hit_idx = l1i_way_idx_t'(w);
		end
	end

	assign cache_hit = |way_hit_oh;

	// Line arriving right now, requester retries and hits next time
	assign near_miss = !cache_hit && ift_instruction_requested && |itag_update_en_oh
		&& itag_update_set == ift_pc.set_idx && itag_update_tag == ift_pc.tag;

	assign ifd_cache_miss = !cache_hit && ift_instruction_requested && !near_miss;
	assign ifd_cache_miss_addr = {ift_pc.tag, ift_pc.set_idx, {`CACHE_LINE_OFFSET_WIDTH{1'b0}}};

	assign ifd_update_lru_en = cache_hit && ift_instruction_requested;
	assign ifd_update_lru_way = way_hit_idx;

	assign perf_icache_hit = cache_hit && ift_instruction_requested;
	assign perf_icache_miss = !cache_hit && ift_instruction_requested;

	// Data array, way selects the upper address bit
	sram_1r1w #(
		.DATA_WIDTH($bits(cache_line_data_t)),
		.SIZE(`L1I_WAYS * `L1I_SETS)
	) data_ram (
		.clk(clk),
		.read_en(cache_hit && ift_instruction_requested),
		.read_addr({way_hit_idx, ift_pc.set_idx}),
		.read_data(fetched_line),
		.write_en(idata_update_en),
		.write_addr({idata_update_way, idata_update_set}),
		.write_data(idata_update_data)
	);

	// Word 0 is in the top lane, so invert the word offset
	assign cache_lane = ~instruction_pc[`CACHE_LINE_OFFSET_WIDTH - 1:2];
	assign fetched_word = fetched_line[32 * cache_lane +: 32];
	assign instruction = {fetched_word[7:0], fetched_word[15:8],
		fetched_word[23:16], fetched_word[31:24]};

	assign rollback_hit = rollback_en && rollback_thread == ift_thread_idx;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			instruction_valid <= 1'b0;
		else
			instruction_valid <= ift_instruction_requested && cache_hit && !rollback_hit;
	end

	// PC and thread follow the data RAM read by one cycle
	always_ff @(posedge clk)
	begin
		instruction_pc <= ift_pc;
		instruction_thread <= ift_thread_idx;
	end
endmodule

/* ifetch_top.sv */
// Instruction fetch front end top level
// Tag stage, data stage and Wishbone line refill engine

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_top
	import l1i_types_pkg::*;
	import fetch_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,

	// Fetch port
	input logic fetch_en,
	input l1i_addr_t fetch_pc,
	input thread_idx_t fetch_thread,
	input logic rollback_en,
	input thread_idx_t rollback_thread,
	output scalar_t instruction,
	output logic instruction_valid,
	output scalar_t instruction_pc,
	output thread_idx_t instruction_thread,
	output logic perf_icache_hit,
	output logic perf_icache_miss,

	// Wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output wb_addr_t wb_adr,
	output logic wb_we,
	output logic [3:0] wb_sel,
	input wb_data_t wb_dat_i,
	input logic wb_ack
);
	// Tag stage outputs
	logic ift_instruction_requested;
	l1i_addr_t ift_pc;
	thread_idx_t ift_thread_idx;
	l1i_tag_t ift_tag[`L1I_WAYS];
	logic ift_valid[`L1I_WAYS];
	l1i_way_idx_t lru_victim_way;

	// Data stage outputs
	logic ifd_update_lru_en;
	l1i_way_idx_t ifd_update_lru_way;
	logic ifd_cache_miss;
	scalar_t ifd_cache_miss_addr;

	// Refill engine outputs
	logic refill_way_req;
	l1i_set_idx_t refill_set;
	logic [`L1I_WAYS - 1:0] itag_update_en_oh;
	l1i_set_idx_t itag_update_set;
	l1i_tag_t itag_update_tag;
	logic idata_update_en;
	l1i_way_idx_t idata_update_way;
	l1i_set_idx_t idata_update_set;
	cache_line_data_t idata_update_data;

	// Port names match the wires above
	ifetch_tag_stage u_ifetch_tag_stage(.*);

	l2_refill u_l2_refill(.*);

	ifetch_data_stage u_ifetch_data_stage(.*);
endmodule

/* ifetch_properties.sv */
// Concurrent checks bound into the data stage and the refill engine
// Hit uniqueness, Wishbone handshake and reset values

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_properties
	import fetch_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`L1I_WAYS - 1:0] hit_oh,
	input logic out_valid,
	input logic cyc,
	input logic stb,
	input logic ack,
	input wb_addr_t adr
);
	// A line lives in one way only
	hit_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_oh))
		else $error("more than one way hit the same request");

	stb_in_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
		else $error("wb_stb high outside a bus cycle");

	// Address held until the slave acks
	adr_hold: assert property (@(posedge clk) disable iff (reset) stb && !ack |=> $stable(adr))
		else $error("wb_adr changed while waiting for ack");

	reset_quiet: assert property (@(posedge clk) reset |=> !out_valid && !cyc && !stb)
		else $error("outputs not low after reset");
endmodule

bind ifetch_data_stage ifetch_properties u_data_props (
	.clk(clk),
	.reset(reset),
	.hit_oh(way_hit_oh),
	.out_valid(instruction_valid),
	.cyc(1'b0),
	.stb(1'b0),
	.ack(1'b0),
	.adr('0)
);

bind l2_refill ifetch_properties u_refill_props (
	.clk(clk),
	.reset(reset),
	.hit_oh('0),
	.out_valid(1'b0),
	.cyc(wb_cyc),
	.stb(wb_stb),
	.ack(wb_ack),
	.adr(wb_adr)
);

/* ifetch_tb.sv */
// Testbench for the instruction fetch front end
// Random fetch stimulus, Wishbone memory with random ack delay
// Cycle model of tags, LRU and refill engine, compare tasks, timeout

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_tb
	import l1i_types_pkg::*;
	import fetch_ctrl_pkg::*;
();
	localparam int N_HIT = 64;
	localparam int N_LRU = 24;
	localparam int N_MIX = 400;
	localparam int NUM_FETCHES = N_HIT + N_LRU + N_MIX + 16;
	// Worst case per fetch is a full line at the longest ack delay
	localparam int CYCLE_LIMIT = NUM_FETCHES * (2 + 8 * 5) + 1000;
	localparam scalar_t PC_A = 32'h0000_100c;
	localparam scalar_t PC_B = 32'h0000_2034;
	localparam scalar_t MIX_BASE = 32'h0000_4000;

	logic clk;
	logic reset;
	logic fetch_en;
	l1i_addr_t fetch_pc;
	thread_idx_t fetch_thread;
	logic rollback_en;
	thread_idx_t rollback_thread;
	scalar_t instruction;
	logic instruction_valid;
	scalar_t instruction_pc;
	thread_idx_t instruction_thread;
	logic perf_icache_hit;
	logic perf_icache_miss;
	logic wb_cyc;
	logic wb_stb;
	wb_addr_t wb_adr;
	logic wb_we;
	logic [3:0] wb_sel;
	wb_data_t wb_dat_i;
	logic wb_ack;

	// Cache and refill model
	l1i_tag_t model_tag[`L1I_SETS][`L1I_WAYS];
	logic model_valid[`L1I_SETS][`L1I_WAYS];
	l1i_way_idx_t model_lru[`L1I_SETS];
	refill_state_t model_state;
	l1i_addr_t fill_addr;
	l1i_way_idx_t fill_way;
	int fill_word;
	int ack_wait;

	// Request in its comparison cycle, result due one cycle later
	logic req_pending;
	l1i_addr_t req_pc;
	thread_idx_t req_thread;
	logic exp_valid;
	scalar_t exp_instr;
	scalar_t exp_pc;
	thread_idx_t exp_thread;

	// Stimulus for the next edge
	logic next_fetch_en;
	l1i_addr_t next_pc;
	thread_idx_t next_thread;
	logic rb_random;
	logic rb_cfg_en;
	thread_idx_t rb_cfg_thread;
	int cycle_count;
	int valid_count;

	ifetch_top u_ifetch_top(.*);

	always #10 clk = ~clk;

	// Memory contents, every address bit reaches the result through the multiply
	function automatic wb_data_t mem_word(wb_addr_t a);
		return (a * 32'h9e37_79b1) ^ (a >> 11) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic scalar_t swap_bytes(scalar_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic check_flag(string what, logic got, logic exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_instruction(string what, scalar_t got, scalar_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_thread(string what, thread_idx_t got, thread_idx_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_bus_addr(string what, wb_addr_t got, wb_addr_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_byte_sel(string what, logic [3:0] got, logic [3:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	// One clock cycle, checked and driven at the falling edge
	task automatic tick();
		logic hit;
		logic near_miss;
		logic rb;
		l1i_way_idx_t hit_way;
		refill_state_t state_next;
		wb_addr_t line_base;

		@(negedge clk);
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end

		// Result registered at the last rising edge
		check_flag("instruction_valid", instruction_valid, exp_valid);
		if (exp_valid)
		begin
			check_instruction("instruction", instruction, exp_instr);
			check_instruction("instruction_pc", instruction_pc, exp_pc);
			check_thread("instruction_thread", instruction_thread, exp_thread);
			valid_count++;
		end

		// Rollback acts in the comparison cycle
		if (rb_random)
		begin
			rollback_en = $urandom_range(0, 3) == 0;
			rollback_thread = thread_idx_t'($urandom_range(0, `NUM_THREADS - 1));
		end
		else
		begin
			rollback_en = rb_cfg_en;
			rollback_thread = rb_cfg_thread;
		end
		rb = rollback_en && rollback_thread == req_thread;

		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `L1I_WAYS; w++)
		begin
			// Way being refilled right now has lost its old line
			if (model_valid[req_pc.set_idx][w] && model_tag[req_pc.set_idx][w] == req_pc.tag
				&& !(model_state == REFILL_WRITE && fill_way == l1i_way_idx_t'(w)
				&& fill_addr.set_idx == req_pc.set_idx))
			begin
				hit = 1'b1;
				hit_way = l1i_way_idx_t'(w);
			end
		end
		// Line landing this cycle is neither a hit nor a new miss
		near_miss = !hit && model_state == REFILL_WRITE
			&& fill_addr.set_idx == req_pc.set_idx && fill_addr.tag == req_pc.tag;
		check_flag("perf_icache_hit", perf_icache_hit, req_pending && hit);
		check_flag("perf_icache_miss", perf_icache_miss, req_pending && !hit);

		exp_valid = req_pending && hit && !rb;
		exp_instr = swap_bytes(mem_word({req_pc[31:2], 2'b00}));
		exp_pc = req_pc;
		exp_thread = req_thread;

		state_next = model_state;
		if (req_pending && hit)
			model_lru[req_pc.set_idx] = ~hit_way;
		else if (req_pending && !near_miss && model_state == REFILL_IDLE)
		begin
			// Least recent way is the victim and turns most recent
			fill_addr = req_pc;
			fill_addr.offset = '0;
			fill_way = model_lru[req_pc.set_idx];
			model_lru[req_pc.set_idx] = ~fill_way;
			fill_word = 0;
			ack_wait = $urandom_range(0, 3);
			state_next = REFILL_BUS;
		end

		// Wishbone slave with random ack delay
		wb_ack = 1'b0;
		wb_dat_i = '0;
		check_flag("wb_cyc", wb_cyc, model_state == REFILL_BUS);
		check_flag("wb_we", wb_we, 1'b0);
		if (model_state != REFILL_BUS)
			check_flag("wb_stb", wb_stb, 1'b0);
		else if (wb_stb)
		begin
			line_base = fill_addr;
			check_bus_addr("wb_adr", wb_adr, line_base + wb_addr_t'(4 * fill_word));
			// Whole-word reads enable all four byte lanes
			check_byte_sel("wb_sel", wb_sel, 4'hf);
			if (ack_wait == 0)
			begin
				wb_ack = 1'b1;
				wb_dat_i = mem_word(wb_adr);
				fill_word++;
				ack_wait = $urandom_range(0, 3);
				if (fill_word == `CACHE_LINE_WORDS)
					state_next = REFILL_WRITE;
			end
			else
				ack_wait--;
		end

		// Tag and data written at the end of this cycle
		if (model_state == REFILL_WRITE)
		begin
			model_tag[fill_addr.set_idx][fill_way] = fill_addr.tag;
			model_valid[fill_addr.set_idx][fill_way] = 1'b1;
			state_next = REFILL_IDLE;
		end
		model_state = state_next;

		fetch_en = next_fetch_en;
		fetch_pc = next_pc;
		fetch_thread = next_thread;
		req_pending = next_fetch_en;
		req_pc = next_pc;
		req_thread = next_thread;
	endtask

	task automatic request(l1i_addr_t pc, thread_idx_t thr);
		next_fetch_en = 1'b1;
		next_pc = pc;
		next_thread = thr;
		tick();
		next_fetch_en = 1'b0;
	endtask

	// Run until no refill, request or result is left in flight
	task automatic settle();
		next_fetch_en = 1'b0;
		tick();
		while (model_state != REFILL_IDLE || req_pending || exp_valid)
			tick();
	endtask

	// Requester retries every cycle until the line is there
	task automatic fetch_until_valid(l1i_addr_t pc, thread_idx_t thr);
		int start;

		start = valid_count;
		while (valid_count == start)
			request(pc, thr);
		settle();
	endtask

	task automatic rollback_case(thread_idx_t rb_thread, logic expect_valid);
		request(PC_A, 2'd1);
		rb_cfg_en = 1'b1;
		rb_cfg_thread = rb_thread;
		tick();
		rb_cfg_en = 1'b0;
		tick();
		check_flag("instruction_valid with rollback", instruction_valid, expect_valid);
	endtask

	initial
	begin
		l1i_tag_t lru_tags[3];
		l1i_set_idx_t lru_set;
		logic [4:0] word_off;
		int pick;

		void'($urandom(32'h8684_f0f4));
		clk = 1'b0;
		reset = 1'b1;
		fetch_en = 1'b0;
		fetch_pc = '0;
		fetch_thread = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		wb_dat_i = '0;
		wb_ack = 1'b0;
		next_fetch_en = 1'b0;
		next_pc = '0;
		next_thread = '0;
		rb_random = 1'b0;
		rb_cfg_en = 1'b0;
		rb_cfg_thread = '0;
		req_pending = 1'b0;
		req_pc = '0;
		req_thread = '0;
		exp_valid = 1'b0;
		exp_instr = '0;
		exp_pc = '0;
		exp_thread = '0;
		model_state = REFILL_IDLE;
		fill_addr = '0;
		fill_way = '0;
		fill_word = 0;
		ack_wait = 0;
		cycle_count = 0;
		valid_count = 0;
		for (int s = 0; s < `L1I_SETS; s++)
		begin
			model_lru[s] = '0;
			for (int w = 0; w < `L1I_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// Cold misses, retried until the refilled line hits
		fetch_until_valid(PC_A, 2'd0);
		fetch_until_valid(PC_B, 2'd3);

		// Result exactly two cycles after the fetch is driven
		request(PC_A, 2'd2);
		tick();
		tick();
		check_flag("instruction_valid two cycles after fetch", instruction_valid, 1'b1);
		for (int n = 0; n < N_HIT; n++)
		begin
			next_fetch_en = 1'b1;
			next_pc = ($urandom_range(0, 1) ? PC_A : PC_B) & ~32'h1f;
			next_pc.offset = 5'($urandom_range(0, 7) << 2);
			next_thread = thread_idx_t'($urandom_range(0, `NUM_THREADS - 1));
			tick();
		end
		settle();

		// Three tags fighting over two ways of one set
		lru_set = l1i_set_idx_t'($urandom_range(0, `L1I_SETS - 1));
		lru_tags[0] = l1i_tag_t'($urandom);
		lru_tags[1] = lru_tags[0] + 1'b1;
		lru_tags[2] = lru_tags[0] + 2'd2;
		for (int n = 0; n < N_LRU; n++)
		begin
			pick = $urandom_range(0, 2);
			word_off = 5'($urandom_range(0, 7) << 2);
			request({lru_tags[pick], lru_set, word_off}, 2'd1);
			settle();
		end

		// Rollback on the same thread drops the result, another thread keeps it
		fetch_until_valid(PC_A, 2'd1);
		rollback_case(2'd1, 1'b0);
		rollback_case(2'd2, 1'b1);
		settle();

		// Random mix over a 1 KB window with random rollbacks
		rb_random = 1'b1;
		for (int n = 0; n < N_MIX; n++)
		begin
			next_fetch_en = $urandom_range(0, 3) != 0;
			next_pc = MIX_BASE + ($urandom_range(0, 255) << 2);
			next_thread = thread_idx_t'($urandom_range(0, `NUM_THREADS - 1));
			tick();
		end
		rb_random = 1'b0;
		settle();

		$display("Simulation PASSED");
		$finish;
	end
endmodule

/* all.f */
+incdir+.
fetch_ctrl_pkg.sv
l1i_types_pkg.sv
sram_1r1w.sv
ifetch_tag_stage.sv
l2_refill.sv
ifetch_data_stage.sv
ifetch_top.sv
ifetch_properties.sv
ifetch_tb.sv

/* Makefile */
VERILATOR = verilator

sim:
	$(VERILATOR) --binary --timing --assert --top-module ifetch_tb -f all.f
	./obj_dir/Vifetch_tb | tee /dev/stderr | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
